// File: source/mt_params.svh
////////////////////////////////////////////////////////////////////////////
// TM03/TU77 formatter constants: widths, register map, function codes
// and status/error bit positions, included by every file that needs them
////////////////////////////////////////////////////////////////////////////

`ifndef MT_PARAMS_SVH
`define MT_PARAMS_SVH

// Field widths
`define MT_REG_W        16              // Massbus register word
`define MT_SEL_W        5               // Register select
`define MT_FUN_W        5               // CS1 function field
`define MT_POS_W        16              // Tape position counter
`define MT_UNIT_W       3               // Massbus unit number

`define MT_UNIT         3'd0            // This formatter's unit

// Register addresses
`define MT_REG_CS1      5'o00           // Control/status
`define MT_REG_DS       5'o01           // Drive status
`define MT_REG_ER       5'o02           // Error
`define MT_REG_MR       5'o03           // Maintenance
`define MT_REG_AS       5'o04           // Attention summary
`define MT_REG_FC       5'o05           // Frame count
`define MT_REG_DT       5'o06           // Drive type
`define MT_REG_CC       5'o07           // Check character
`define MT_REG_SN       5'o10           // Serial number
`define MT_REG_TC       5'o11           // Tape control, highest valid

// Function codes, TM03 encoding
`define MT_FUN_DRVCLR   5'o04
`define MT_FUN_PRESET   5'o10
`define MT_FUN_ERASE    5'o12
`define MT_FUN_WRTM     5'o13
`define MT_FUN_SPCFWD   5'o14
`define MT_FUN_SPCREV   5'o15

// Drive status bits
`define MT_DS_ATA       15
`define MT_DS_ERR       14
`define MT_DS_PIP       13
`define MT_DS_MOL       12
`define MT_DS_WRL       11
`define MT_DS_DRY       7
`define MT_DS_BOT       1

// Error register bits
`define MT_ER_UNS       14
`define MT_ER_NEF       11
`define MT_ER_RMR       2
`define MT_ER_ILR       1
`define MT_ER_ILF       0

// Identity and preset values
`define MT_DRV_TYPE     16'o046054      // TAP, DRQ, SPR, TU77
`define MT_DRV_SN       16'h0023        // BCD serial number
`define MT_TC_PRESET    16'o002000      // 1600 bpi, all else clear

`endif

// File: source/mtPkg.sv
////////////////////////////////////////////////////////////////////////////
// Types shared by the tape controller modules and interfaces
////////////////////////////////////////////////////////////////////////////

`include "mt_params.svh"

package mtPkg;

   typedef logic [`MT_REG_W-1:0] mtReg_t;      // One register word
   typedef logic [`MT_SEL_W-1:0] mtRegSel_t;   // Register address
   typedef logic [`MT_FUN_W-1:0] mtFun_t;      // Function code
   typedef logic [`MT_POS_W-1:0] mtPos_t;      // Frames from BOT

   // Error set strobes, one cycle each
   typedef struct packed {
      logic uns;                                // Unsafe
      logic nef;                                // Non-executable function
      logic rmr;                                // Register modify refused
      logic ilr;                                // Illegal register
      logic ilf;                                // Illegal function
   } mtErrSet_t;

endpackage

// File: source/mtBuses.sv
////////////////////////////////////////////////////////////////////////////
// Internal buses: decoder to register file, register file to sequencer
////////////////////////////////////////////////////////////////////////////

// Decoder strobes into the register file
interface mtRegBus;
   import mtPkg::*;

   logic      wrFc;                             // Frame count write
   logic      wrTc;                             // Tape control write
   logic      wrMr;                             // Maintenance write
   logic      clrAttn;                          // AS write with our bit set
   logic      drvClr;                           // Drive clear function
   logic      preset;                           // Read-in preset function
   logic      space;                            // Accepted space command
   logic      reverse;                          // Direction, valid with space
   mtErrSet_t errSet;                           // Error set strobes
   logic      cmdDone;                          // Immediate function done
   mtReg_t    wrData;                           // Write data
   logic      ready;                            // DRY back to the decoder
   logic      atBot;
   logic      fcZero;

   modport decode (
      output wrFc, wrTc, wrMr, clrAttn, drvClr, preset, space, reverse,
      output errSet, cmdDone, wrData,
      input  ready, atBot, fcZero
   );

   modport regs (
      input  wrFc, wrTc, wrMr, clrAttn, drvClr, preset, space, reverse,
      input  errSet, cmdDone, wrData,
      output ready, atBot, fcZero
   );

endinterface

// Frame count and motion handshake
interface mtMotionBus;
   import mtPkg::*;

   logic   start;                               // Begin spacing, one pulse
   logic   reverse;                             // Sampled with start
   mtReg_t fc;                                  // Current frame count
   logic   drvClr;                              // Abort motion
   logic   busy;                                // Spacing in progress
   logic   incFc;                               // One frame moved
   logic   done;                                // Last frame moved
   logic   atBot;                               // Position is zero

   modport regs (
      output start, reverse, fc, drvClr,
      input  busy, incFc, done, atBot
   );

   modport seq (
      input  start, reverse, fc, drvClr,
      output busy, incFc, done, atBot
   );

endinterface

// File: source/mtCommandDecode.sv
////////////////////////////////////////////////////////////////////////////
// Massbus write and GO decoder: register strobes, commands, error sets
////////////////////////////////////////////////////////////////////////////

`include "mt_params.svh"

module mtCommandDecode (
   input  logic                  clk,
   input  logic                  rst,
   input  logic [`MT_UNIT_W-1:0] unit,
   input  logic                  read,
   input  logic                  write,
   input  logic                  go,
   input  mtPkg::mtRegSel_t      regSel,
   input  mtPkg::mtFun_t         fun,
   input  mtPkg::mtReg_t         dataIn,
   input  logic                  writeLock,
   input  logic                  mediaOnline,
   mtRegBus.decode               bus
);

   logic unitSel;                               // Unit matches ours
   logic wrSel;
   logic goSel;
   logic guardedWr;                             // CS1, FC or TC write
   logic goDly;                                 // GO one cycle late, not DRVCLR
   logic fnDrvClr;
   logic fnPreset;
   logic fnErase;
   logic fnWrtm;
   logic fnSpcFwd;
   logic fnSpcRev;
   logic fnLegal;
   logic nef;

   assign unitSel = (unit == `MT_UNIT);
   assign wrSel   = write & unitSel;
   assign goSel   = go & unitSel;

   ////////////////////////////////////////////////////////////////////////////
   // Register writes
   ////////////////////////////////////////////////////////////////////////////

   // Only MR and AS may change during motion
   assign guardedWr = wrSel & ((regSel == `MT_REG_CS1) |
                               (regSel == `MT_REG_FC)  |
                               (regSel == `MT_REG_TC));

   assign bus.wrFc    = wrSel & (regSel == `MT_REG_FC) & bus.ready;
   assign bus.wrTc    = wrSel & (regSel == `MT_REG_TC) & bus.ready;
   assign bus.wrMr    = wrSel & (regSel == `MT_REG_MR);
   assign bus.clrAttn = wrSel & (regSel == `MT_REG_AS) & dataIn[`MT_UNIT];
   assign bus.wrData  = dataIn;

   ////////////////////////////////////////////////////////////////////////////
   // Function decode
   ////////////////////////////////////////////////////////////////////////////

   assign fnDrvClr = goSel & (fun == `MT_FUN_DRVCLR);
   assign fnPreset = goSel & (fun == `MT_FUN_PRESET);
   assign fnErase  = goSel & (fun == `MT_FUN_ERASE);
   assign fnWrtm   = goSel & (fun == `MT_FUN_WRTM);
   assign fnSpcFwd = goSel & (fun == `MT_FUN_SPCFWD);
   assign fnSpcRev = goSel & (fun == `MT_FUN_SPCREV);

   // Transfer, rewind and unload all fall out as illegal
   assign fnLegal = fnDrvClr | fnPreset | fnErase | fnWrtm | fnSpcFwd | fnSpcRev;

   // Write lock, reverse at BOT, space with nothing to count
   assign nef = ((fnErase | fnWrtm) & writeLock) |
                (fnSpcRev & bus.atBot) |
                ((fnSpcFwd | fnSpcRev) & bus.fcZero);

   assign bus.drvClr  = fnDrvClr;
   assign bus.preset  = fnPreset;
   assign bus.space   = (fnSpcFwd | fnSpcRev) & ~nef & mediaOnline & bus.ready;
   assign bus.reverse = fnSpcRev;
   assign bus.cmdDone = (fnErase | fnWrtm) & ~nef & mediaOnline;  // No tape motion

   // Delayed GO so a preset settles before MOL is judged
   always_ff @(posedge clk)
   begin
      if (rst)
         goDly <= 1'b0;
      else
         goDly <= goSel & (fun != `MT_FUN_DRVCLR);
   end

   ////////////////////////////////////////////////////////////////////////////
   // Error sets
   ////////////////////////////////////////////////////////////////////////////

   assign bus.errSet.uns = goDly & ~mediaOnline;
   assign bus.errSet.nef = nef;
   assign bus.errSet.rmr = guardedWr & ~bus.ready;      // Refused, not stored
   assign bus.errSet.ilr = (read | write) & unitSel & (regSel > `MT_REG_TC);
   assign bus.errSet.ilf = goSel & ~fnLegal;

   // One register strobe per bus cycle
   assert property (@(posedge clk) disable iff (rst)
      $onehot0({bus.wrFc, bus.wrTc, bus.wrMr, bus.clrAttn}));

endmodule

// File: source/mtRegisterFile.sv
////////////////////////////////////////////////////////////////////////////
// FC, TC, MR, ER and attention state, drive status and the read mux
////////////////////////////////////////////////////////////////////////////

`include "mt_params.svh"

module mtRegisterFile (
   input  logic             clk,
   input  logic             rst,
   input  logic             init,
   input  logic             mediaOnline,
   input  logic             writeLock,
   input  mtPkg::mtRegSel_t regSel,
   mtRegBus.regs            bus,
   mtMotionBus.regs         motion,
   output mtPkg::mtReg_t    regData,
   output logic             attn,
   output logic             driveReady
);

   import mtPkg::*;

   mtReg_t fc;                                  // Two's complement frame count
   mtReg_t tc;
   mtReg_t mr;
   mtReg_t er;
   mtReg_t ds;                                  // Built, not stored
   mtReg_t asWord;
   mtReg_t errBits;                             // Error sets in ER layout
   logic   ata;
   logic   clear;                               // Init or drive clear

   assign clear = init | bus.drvClr;

   // Back to the decoder and the sequencer
   assign bus.ready      = ~motion.busy;
   assign bus.atBot      = motion.atBot;
   assign bus.fcZero     = (fc == '0);
   assign motion.start   = bus.space;
   assign motion.reverse = bus.reverse;
   assign motion.fc      = fc;
   assign motion.drvClr  = bus.drvClr;

   ////////////////////////////////////////////////////////////////////////////
   // Stored registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst | clear)
         fc <= '0;
      else if (bus.wrFc)
         fc <= bus.wrData;
      else if (motion.incFc)
         fc <= fc + 1'b1;                       // Counts up toward zero
   end

   // Drive clear leaves TC alone
   always_ff @(posedge clk)
   begin
      if (rst | init)
         tc <= '0;
      else if (bus.preset)
         tc <= `MT_TC_PRESET;
      else if (bus.wrTc)
         tc <= bus.wrData;
   end

   always_ff @(posedge clk)
   begin
      if (rst | init)
         mr <= '0;
      else if (bus.wrMr)
         mr <= bus.wrData;
   end

   always_comb
   begin
      errBits = '0;
      errBits[`MT_ER_UNS] = bus.errSet.uns;
      errBits[`MT_ER_NEF] = bus.errSet.nef;
      errBits[`MT_ER_RMR] = bus.errSet.rmr;
      errBits[`MT_ER_ILR] = bus.errSet.ilr;
      errBits[`MT_ER_ILF] = bus.errSet.ilf;
   end

   always_ff @(posedge clk)
   begin
      if (rst | clear)
         er <= '0;
      else
         er <= er | errBits;                    // Sticky until cleared
   end

   // Attention, set wins over an AS clear
   always_ff @(posedge clk)
   begin
      if (rst | clear)
         ata <= 1'b0;
      else if ((|errBits) | bus.cmdDone | motion.done)
         ata <= 1'b1;
      else if (bus.clrAttn)
         ata <= 1'b0;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Status and reads
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      ds = '0;
      ds[`MT_DS_ATA] = ata;
      ds[`MT_DS_ERR] = |er;
      ds[`MT_DS_PIP] = motion.busy;
      ds[`MT_DS_MOL] = mediaOnline;
      ds[`MT_DS_WRL] = writeLock;
      ds[`MT_DS_DRY] = ~motion.busy;
      ds[`MT_DS_BOT] = motion.atBot;
      asWord = '0;
      asWord[`MT_UNIT] = ata;                   // Our slot in the summary
   end

   always_comb
   begin
      case (regSel)
         `MT_REG_DS: regData = ds;
         `MT_REG_ER: regData = er;
         `MT_REG_MR: regData = mr;
         `MT_REG_AS: regData = asWord;
         `MT_REG_FC: regData = fc;
         `MT_REG_DT: regData = `MT_DRV_TYPE;
         `MT_REG_SN: regData = `MT_DRV_SN;
         `MT_REG_TC: regData = tc;
         default:    regData = '0;              // CS1, CC, illegal
      endcase
   end

   assign attn       = ata;
   assign driveReady = ~motion.busy;

   // Decoder must hold off FC writes during motion
   assert property (@(posedge clk) disable iff (rst) bus.wrFc |-> !motion.busy);

endmodule

// File: source/mtMotionSequencer.sv
////////////////////////////////////////////////////////////////////////////
// Space sequencer: one frame per clock, tracks tape position and BOT
////////////////////////////////////////////////////////////////////////////

module mtMotionSequencer (
   input logic     clk,
   input logic     rst,
   input logic     init,
   mtMotionBus.seq motion
);

   import mtPkg::*;

   typedef enum logic {
      stIdle,
      stSpace
   } seqState_t;

   seqState_t state;
   logic      dirRev;                           // Latched with start
   mtPos_t    pos;                              // Frames from BOT
   logic      spacing;
   logic      lastFrame;

   assign spacing = (state == stSpace);

   // Next FC is zero, or reverse is about to hit BOT
   assign lastFrame = (motion.fc == '1) | (dirRev & (pos == mtPos_t'(1)));

   always_ff @(posedge clk)
   begin
      if (rst | init)
      begin
         state  <= stIdle;
         dirRev <= 1'b0;
         pos    <= '0;                          // Loaded at BOT
      end
      else if (motion.drvClr)
         state <= stIdle;                       // Abort, tape stays put
      else
      begin
         case (state)
            stIdle:
               if (motion.start)
               begin
                  state  <= stSpace;
                  dirRev <= motion.reverse;
               end
            stSpace:
            begin
               if (dirRev)
                  pos <= pos - 1'b1;
               else
                  pos <= pos + 1'b1;
               if (lastFrame)
                  state <= stIdle;
            end
            default: state <= stIdle;
         endcase
      end
   end

   assign motion.busy  = spacing;
   assign motion.incFc = spacing;               // One frame this cycle
   assign motion.done  = spacing & lastFrame;
   assign motion.atBot = (pos == '0);

   // NEF in the decoder keeps reverse spaces off BOT
   assert property (@(posedge clk) disable iff (rst)
      (spacing && dirRev) |-> (pos != '0));

endmodule

// File: source/mtTapeCtrl.sv
////////////////////////////////////////////////////////////////////////////
// Tape controller top level with Massbus-style register ports
////////////////////////////////////////////////////////////////////////////

`include "mt_params.svh"

module mtTapeCtrl (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  init,          // Massbus initialize
   input  logic [`MT_UNIT_W-1:0] unit,
   input  logic                  read,
   input  logic                  write,
   input  logic                  go,
   input  mtPkg::mtRegSel_t      regSel,
   input  mtPkg::mtFun_t         fun,
   input  mtPkg::mtReg_t         dataIn,
   input  logic                  writeLock,
   input  logic                  mediaOnline,
   output mtPkg::mtReg_t         regData,
   output logic                  regAck,
   output logic                  attn,
   output logic                  driveReady
);

   mtRegBus    regBus ();
   mtMotionBus motionBus ();

   mtCommandDecode u_mtCommandDecode (
      .clk         (clk),
      .rst         (rst),
      .unit        (unit),
      .read        (read),
      .write       (write),
      .go          (go),
      .regSel      (regSel),
      .fun         (fun),
      .dataIn      (dataIn),
      .writeLock   (writeLock),
      .mediaOnline (mediaOnline),
      .bus         (regBus.decode)
   );

   mtRegisterFile u_mtRegisterFile (
      .clk         (clk),
      .rst         (rst),
      .init        (init),
      .mediaOnline (mediaOnline),
      .writeLock   (writeLock),
      .regSel      (regSel),
      .bus         (regBus.regs),
      .motion      (motionBus.regs),
      .regData     (regData),
      .attn        (attn),
      .driveReady  (driveReady)
   );

   mtMotionSequencer u_mtMotionSequencer (
      .clk         (clk),
      .rst         (rst),
      .init        (init),
      .motion      (motionBus.seq)
   );

   // Valid selects on our unit
   assign regAck = (unit == `MT_UNIT) & (regSel <= `MT_REG_TC);

endmodule

// File: dv/mtTapeCtrlTb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the tape controller covering register access, errors and spacing
// Holds the reference model and compares every read cycle on the negedge
////////////////////////////////////////////////////////////////////////////

`include "mt_params.svh"

module mtTapeCtrlTb;

   localparam int numTests = 5;
   localparam int maxSpace = 40;                // Largest random frame count

   logic                  clk;
   logic                  rst;
   logic                  init;
   logic [`MT_UNIT_W-1:0] unit;
   logic                  read;
   logic                  write;
   logic                  go;
   logic [`MT_SEL_W-1:0]  regSel;
   logic [`MT_FUN_W-1:0]  fun;
   logic [`MT_REG_W-1:0]  dataIn;
   logic                  writeLock;
   logic                  mediaOnline;
   logic [`MT_REG_W-1:0]  regData;
   logic                  regAck;
   logic                  attn;
   logic                  driveReady;

   // Reference state
   logic [`MT_REG_W-1:0]  mFc;
   logic [`MT_REG_W-1:0]  mTc;
   logic [`MT_REG_W-1:0]  mMr;
   logic [`MT_REG_W-1:0]  mEr;
   logic                  mAta;
   logic                  mBusy;
   int                    mPos;                 // Frames from BOT
   int                    frames;               // Expected length of current space
   logic                  spaceRev;
   logic                  checkEn;              // Compare on the next negedge
   integer                seed;
   int                    failCount;
   string                 testName;

   initial clk = 1'b0;
   always #20 clk = ~clk;

   mtTapeCtrl u_mtTapeCtrl (
      .clk         (clk),
      .rst         (rst),
      .init        (init),
      .unit        (unit),
      .read        (read),
      .write       (write),
      .go          (go),
      .regSel      (regSel),
      .fun         (fun),
      .dataIn      (dataIn),
      .writeLock   (writeLock),
      .mediaOnline (mediaOnline),
      .regData     (regData),
      .regAck      (regAck),
      .attn        (attn),
      .driveReady  (driveReady)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [`MT_REG_W-1:0] expectReg(input logic [`MT_SEL_W-1:0] sel);
      logic [`MT_REG_W-1:0] ds;
      ds = '0;
      ds[`MT_DS_ATA] = mAta;
      ds[`MT_DS_ERR] = |mEr;                    // Any error bit
      ds[`MT_DS_PIP] = mBusy;
      ds[`MT_DS_MOL] = mediaOnline;
      ds[`MT_DS_WRL] = writeLock;
      ds[`MT_DS_DRY] = !mBusy;
      ds[`MT_DS_BOT] = (mPos == 0);
      case (sel)
         `MT_REG_DS: return ds;
         `MT_REG_ER: return mEr;
         `MT_REG_MR: return mMr;
         `MT_REG_AS: return {15'b0, mAta};      // Unit 0 slot
         `MT_REG_FC: return mFc;
         `MT_REG_DT: return `MT_DRV_TYPE;
         `MT_REG_SN: return `MT_DRV_SN;
         `MT_REG_TC: return mTc;
         default:    return '0;                 // CS1 and CC hold nothing
      endcase
   endfunction

   function automatic logic expectAck(input logic [`MT_SEL_W-1:0] sel);
      return (unit == `MT_UNIT) && (sel <= `MT_REG_TC);
   endfunction

   function automatic int randBelow(input int limit);
      logic [31:0] r;
      r = $random(seed);
      return int'(r % limit);
   endfunction

   task automatic checkValue(input string what, input logic [`MT_REG_W-1:0] expected,
                             input logic [`MT_REG_W-1:0] actual);
      if (actual !== expected)
      begin
         failCount++;
         $display("error %s %s: expected %h actual %h", testName, what, expected, actual);
         $display("tests failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic setError(input int bitPos);
      mEr[bitPos] = 1'b1;
      mAta        = 1'b1;                       // Every error raises attention
   endtask

   task automatic modelClear(input logic isInit);
      mFc   = '0;
      mEr   = '0;
      mAta  = 1'b0;
      mBusy = 1'b0;
      if (isInit)
      begin
         mTc  = '0;
         mMr  = '0;
         mPos = 0;                              // Back at BOT
      end
   endtask

   // Write rules applied after the edge that takes the write
   task automatic modelWrite(input logic [`MT_SEL_W-1:0] sel, input logic [`MT_REG_W-1:0] data);
      if (unit == `MT_UNIT)
      begin
         if (sel > `MT_REG_TC)
            setError(`MT_ER_ILR);
         else if (mBusy && (sel == `MT_REG_CS1 || sel == `MT_REG_FC || sel == `MT_REG_TC))
            setError(`MT_ER_RMR);               // Refused during motion
         else if (sel == `MT_REG_FC)
            mFc = data;
         else if (sel == `MT_REG_TC)
            mTc = data;
         else if (sel == `MT_REG_MR)
            mMr = data;
         else if (sel == `MT_REG_AS && data[`MT_UNIT])
            mAta = 1'b0;
      end
   endtask

   task automatic modelGo(input logic [`MT_FUN_W-1:0] f);
      case (f)
         `MT_FUN_DRVCLR: modelClear(1'b0);
         `MT_FUN_PRESET: mTc = `MT_TC_PRESET;
         `MT_FUN_ERASE, `MT_FUN_WRTM:
            if (writeLock)
               setError(`MT_ER_NEF);
            else if (mediaOnline)
               mAta = 1'b1;                     // Completes at once
         `MT_FUN_SPCFWD, `MT_FUN_SPCREV:
            if (mFc == '0 || (f == `MT_FUN_SPCREV && mPos == 0))
               setError(`MT_ER_NEF);
         default: setError(`MT_ER_ILF);         // Transfers and the rest
      endcase
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Bus stimulus
   ////////////////////////////////////////////////////////////////////////////

   task automatic regWrite(input logic [`MT_SEL_W-1:0] sel, input logic [`MT_REG_W-1:0] data);
      @(posedge clk);
      write  <= 1'b1;
      regSel <= sel;
      dataIn <= data;
      @(posedge clk);
      write <= 1'b0;
      modelWrite(sel, data);
   endtask

   task automatic readCheck(input logic [`MT_SEL_W-1:0] sel, input logic strobe);
      @(posedge clk);
      read    <= strobe;
      regSel  <= sel;
      checkEn <= 1'b1;
      @(posedge clk);
      read    <= 1'b0;
      checkEn <= 1'b0;
      if (strobe && unit == `MT_UNIT && sel > `MT_REG_TC)
         setError(`MT_ER_ILR);
   endtask

   task automatic readRange(input int last);
      for (int s = 0; s <= last; s++)
         readCheck(5'(s), 1'b0);
   endtask

   task automatic goFunction(input logic [`MT_FUN_W-1:0] f);
      @(posedge clk);
      go  <= 1'b1;
      fun <= f;
      @(posedge clk);
      go <= 1'b0;
      modelGo(f);
      @(posedge clk);                           // UNS lands one edge later
      if (!mediaOnline && f != `MT_FUN_DRVCLR)
         setError(`MT_ER_UNS);
   endtask

   task automatic pulseInit();
      @(posedge clk);
      init <= 1'b1;
      @(posedge clk);
      init <= 1'b0;
      modelClear(1'b1);
   endtask

   // Starts a space from the loaded FC and returns on the first busy negedge
   task automatic startSpace(input logic rev);
      logic [`MT_REG_W-1:0] count;
      count    = -mFc;
      spaceRev = rev;
      frames   = (rev && mPos < count) ? mPos : count;
      @(posedge clk);
      go  <= 1'b1;
      fun <= rev ? `MT_FUN_SPCREV : `MT_FUN_SPCFWD;
      @(posedge clk);
      go    <= 1'b0;
      mBusy = 1'b1;
      @(negedge clk);
      checkValue("driveReady during space", 1'b0, driveReady);
   endtask

   task automatic finishSpace(input logic countFrames);
      int lowCycles;
      lowCycles = 1;                            // First busy negedge already seen
      @(negedge clk);
      while (!driveReady)
      begin
         lowCycles++;
         @(negedge clk);
      end
      if (countFrames)
         checkValue("frames moved", frames, lowCycles);
      mBusy = 1'b0;
      mFc   = mFc + frames;                     // Counts up toward zero
      mPos  = spaceRev ? mPos - frames : mPos + frames;
      mAta  = 1'b1;
   endtask

   // Negedge compare of every read cycle
   always @(negedge clk)
   begin
      if (checkEn)
      begin
         checkValue($sformatf("register %0o", regSel), expectReg(regSel), regData);
         checkValue("regAck", expectAck(regSel), regAck);
         checkValue("attn", mAta, attn);
         checkValue("driveReady", !mBusy, driveReady);
      end
   end

   // Watchdog
   initial
   begin
      repeat (numTests * 200 + maxSpace) @(posedge clk);
      $display("watchdog: run did not finish within %0d cycles", numTests * 200 + maxSpace);
      $display("tests failed");
      $fatal(1, "timeout");
   end

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      seed        = 23721;
      failCount   = 0;
      rst         = 1'b1;
      init        = 1'b0;
      unit        = `MT_UNIT;
      read        = 1'b0;
      write       = 1'b0;
      go          = 1'b0;
      regSel      = '0;
      fun         = '0;
      dataIn      = '0;
      writeLock   = 1'b0;
      mediaOnline = 1'b1;
      checkEn     = 1'b0;
      modelClear(1'b1);
      testName = "reset";
      repeat (16) @(posedge clk);
      rst <= 1'b0;

      testName = "reset and access";
      readRange(31);                            // Ack and zero state
      regWrite(`MT_REG_FC, 16'(randBelow(65536)));
      regWrite(`MT_REG_TC, 16'(randBelow(65536)));
      regWrite(`MT_REG_MR, 16'(randBelow(65536)));
      readRange(`MT_REG_TC);
      @(posedge clk);
      unit <= 3'd5;                             // Another unit is ignored
      regWrite(`MT_REG_MR, 16'(randBelow(65536)));
      readCheck(`MT_REG_MR, 1'b0);
      @(posedge clk);
      unit <= `MT_UNIT;

      testName = "illegal access";
      readCheck(5'(10 + randBelow(22)), 1'b1);
      readRange(`MT_REG_TC);
      goFunction(`MT_FUN_DRVCLR);
      regWrite(5'(10 + randBelow(22)), 16'(randBelow(65536)));
      goFunction(5'o24 + 5'(4 * randBelow(3)));  // Write check, write or read
      readRange(`MT_REG_TC);
      goFunction(`MT_FUN_DRVCLR);
      readRange(`MT_REG_TC);
      regWrite(`MT_REG_TC, 16'(randBelow(65536)));
      regWrite(`MT_REG_MR, 16'(randBelow(65536)));
      pulseInit();
      readRange(`MT_REG_TC);

      testName = "space forward";
      regWrite(`MT_REG_FC, 16'(-(1 + randBelow(maxSpace))));
      startSpace(1'b0);
      finishSpace(1'b1);
      readRange(`MT_REG_TC);
      // Long enough to stay busy through three refused writes and a DS read
      regWrite(`MT_REG_FC, 16'(-(8 + randBelow(maxSpace - 7))));
      startSpace(1'b0);
      regWrite(`MT_REG_CS1, 16'(randBelow(65536)));
      regWrite(`MT_REG_FC, 16'(randBelow(65536)));
      regWrite(`MT_REG_TC, 16'(randBelow(65536)));
      readCheck(`MT_REG_DS, 1'b0);              // PIP up and DRY down
      finishSpace(1'b0);
      readRange(`MT_REG_TC);

      testName = "space reverse";
      goFunction(`MT_FUN_DRVCLR);
      regWrite(`MT_REG_FC, 16'(-(1 + randBelow(mPos - 1))));  // Stops short of BOT
      startSpace(1'b1);
      finishSpace(1'b1);
      readRange(`MT_REG_TC);
      regWrite(`MT_REG_FC, 16'(-(mPos + 5)));   // Runs into BOT
      startSpace(1'b1);
      finishSpace(1'b1);
      readRange(`MT_REG_TC);
      goFunction(`MT_FUN_SPCREV);
      readRange(`MT_REG_TC);

      testName = "erase and tape mark";
      goFunction(`MT_FUN_DRVCLR);
      @(posedge clk);
      writeLock <= 1'b1;
      goFunction(`MT_FUN_ERASE);
      readRange(`MT_REG_TC);
      goFunction(`MT_FUN_DRVCLR);
      goFunction(`MT_FUN_WRTM);
      readRange(`MT_REG_TC);
      @(posedge clk);
      writeLock <= 1'b0;
      goFunction(`MT_FUN_DRVCLR);
      goFunction(`MT_FUN_ERASE);
      readRange(`MT_REG_TC);
      regWrite(`MT_REG_AS, 16'h0001);
      readRange(`MT_REG_TC);
      @(posedge clk);
      mediaOnline <= 1'b0;                      // Medium off-line
      goFunction(`MT_FUN_PRESET);
      readRange(`MT_REG_TC);
      goFunction(`MT_FUN_DRVCLR);
      readRange(`MT_REG_TC);
      regWrite(`MT_REG_FC, 16'(-3));
      goFunction(`MT_FUN_SPCFWD);
      readRange(`MT_REG_TC);
      regWrite(`MT_REG_AS, 16'h0001);
      readRange(`MT_REG_TC);
      @(posedge clk);
      mediaOnline <= 1'b1;
      pulseInit();
      readRange(`MT_REG_TC);

      if (failCount == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// File: mtTapeCtrl.f
+incdir+source
source/mtPkg.sv
source/mtBuses.sv
source/mtCommandDecode.sv
source/mtRegisterFile.sv
source/mtMotionSequencer.sv
source/mtTapeCtrl.sv
dv/mtTapeCtrlTb.sv

// File: Bender.yml
package:
  name: mt_tape_ctrl

sources:
  - include_dirs:
      - source
    files:
      - source/mtPkg.sv
      - source/mtBuses.sv
      - source/mtCommandDecode.sv
      - source/mtRegisterFile.sv
      - source/mtMotionSequencer.sv
      - source/mtTapeCtrl.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/mtTapeCtrlTb.sv
